// File: list.f
hw/rvPkg.sv
hw/pipeControl.sv
hw/immGen.sv
hw/regFile.sv
hw/execUnit.sv
hw/loadStoreAlign.sv
hw/cpuCore.sv
verif/rvRefModel.sv
verif/cpuCoreTb.sv

// File: verif/cpuCoreTb.sv
`timescale 1ns/100ps

module cpuCoreTb import rvPkg::*; ;

   localparam int numPrograms = 12;

   logic        clk;
   logic        rst;
   logic [31:0] imemData;
   logic [31:0] dmemRdata;
   logic [31:0] imemAddr;
   dmemReq_t    dmemReq;
   retire_t     retire;

   logic [31:0] imem [0:127];
   logic [7:0]  dmem [0:255];
   logic [29:0] imemIdx;
   logic [31:0] dmemAddrQ;

   int errCount;
   int testsPassed;
   int testsFailed;

   cpuCore #(.resetPc(32'h0000_0000)) cpuCore_inst (
      .clk       (clk),
      .rst       (rst),
      .imemData  (imemData),
      .dmemRdata (dmemRdata),
      .imemAddr  (imemAddr),
      .dmemReq   (dmemReq),
      .retire    (retire)
   );

   rvRefModel refModel ();

   always #5 clk = ~clk;

   // Both memories answer one cycle after the address
   always @(posedge clk) begin
      imemIdx <= imemAddr[31:2];
      dmemAddrQ <= dmemReq.addr;
      if (dmemReq.valid && dmemReq.we)
         for (int i = 0; i < 4; i++)
            if (dmemReq.byteEn[i])
               dmem[{dmemReq.addr[7:2], i[1:0]}] <= dmemReq.wdata[8*i +: 8];
   end

   always @(negedge clk) begin
      imemData <= (imemIdx < 30'd128) ? imem[imemIdx] : nopInstr;
      dmemRdata <= {dmem[{dmemAddrQ[7:2], 2'd3}], dmem[{dmemAddrQ[7:2], 2'd2}],
                    dmem[{dmemAddrQ[7:2], 2'd1}], dmem[{dmemAddrQ[7:2], 2'd0}]};
   end

   task automatic checkValue(string name, logic [31:0] exp, logic [31:0] act);
      if (exp !== act) begin
         $display("FAILED %s expected %08h actual %08h", name, exp, act);
         errCount++;
      end
   endtask

   function automatic int rnd(int n);
      return $urandom % n;
   endfunction

   task automatic putInstr(inout int idx, input logic [31:0] word);
      if (idx < 128) begin
         imem[idx] = word;
         refModel.prog[idx] = word;
      end
      idx++;
   endtask

   function automatic logic [31:0] encI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   task automatic genProgram();
      logic [2:0]  brF3 [6];
      logic [2:0]  ldF3 [5];
      logic [2:0]  f3;
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [11:0] imm;
      logic [12:0] off;
      logic [20:0] joff;
      int          idx;
      int          step;
      int          tgt;
      int          maxTarget;
      brF3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
      ldF3 = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
      for (int i = 0; i < 128; i++) begin
         imem[i] = nopInstr;
         refModel.prog[i] = nopInstr;
      end
      idx = 0;
      maxTarget = 0;
      // x31 holds the data window base
      putInstr(idx, encI(12'h100, 5'd0, 3'd0, 5'd31, 7'b0010011));
      while (idx < 64) begin
         rd = 5'(rnd(8));
         rs1 = 5'(rnd(8));
         rs2 = 5'(rnd(8));
         case (rnd(10))
            0, 1: begin
               f3 = 3'(rnd(8));
               putInstr(idx, {((f3 == 3'd0 || f3 == 3'd5) && rnd(2) == 1) ? 7'h20 : 7'h00,
                              rs2, rs1, f3, rd, 7'b0110011});
            end
            2, 3: begin
               f3 = 3'(rnd(8));
               imm = 12'(rnd(4096));
               if (f3 == 3'd1)
                  imm = {7'h00, imm[4:0]};
               else if (f3 == 3'd5)
                  imm = {rnd(2) == 1 ? 7'h20 : 7'h00, imm[4:0]};
               putInstr(idx, encI(imm, rs1, f3, rd, 7'b0010011));
            end
            4: begin
               putInstr(idx, {20'(rnd(1 << 20)), rd,
                              rnd(2) == 1 ? 7'b0110111 : 7'b0010111});
            end
            5: begin
               step = 2 + rnd(4);
               off = 13'(step * 4);
               if (idx + step > maxTarget)
                  maxTarget = idx + step;
               putInstr(idx, {off[12], off[10:5], rs2, rs1, brF3[rnd(6)], off[4:1],
                              off[11], 7'b1100011});
            end
            6: begin
               step = 2 + rnd(4);
               joff = 21'(step * 4);
               if (idx + step > maxTarget)
                  maxTarget = idx + step;
               putInstr(idx, {joff[20], joff[10:1], joff[11], joff[19:12], rd,
                              7'b1101111});
            end
            7: begin
               f3 = ldF3[rnd(5)];
               imm = 12'(rnd(256) & ~((1 << f3[1:0]) - 1));
               putInstr(idx, encI(imm, 5'd31, f3, rd, 7'b0000011));
            end
            8: begin
               f3 = 3'(rnd(3));
               imm = 12'(rnd(256) & ~((1 << f3[1:0]) - 1));
               putInstr(idx, {imm[11:5], rs2, 5'd31, f3, imm[4:0], 7'b0100011});
            end
            default: begin
               // JALR target is built in x30 by LUI and ADDI
               // Only placed where no earlier jump can land inside the sequence
               if (idx >= maxTarget) begin
                  tgt = idx + 3 + rnd(4);
                  imm = 12'(tgt * 4);
                  maxTarget = tgt;
                  putInstr(idx, {20'h00000, 5'd30, 7'b0110111});
                  putInstr(idx, encI(imm, 5'd30, 3'd0, 5'd30, 7'b0010011));
                  putInstr(idx, encI(12'h000, 5'd30, 3'd0, rd, 7'b1100111));
               end
            end
         endcase
      end
   endtask

   task automatic runTest(int num);
      string name;
      int    startErr;
      int    idle;
      int    cyc;
      logic  stalled;
      name = $sformatf("program %0d", num);
      startErr = errCount;
      genProgram();
      for (int a = 0; a < 256; a++) begin
         dmem[a] = 8'((a * 29) ^ (a >> 3) ^ (num * 7));
         refModel.mem[a] = dmem[a];
      end
      refModel.runProgram();
      @(negedge clk);
      rst = 1'b1;
      repeat (16) @(negedge clk);
      rst = 1'b0;
      #1;
      checkValue({name, " first fetch address"}, 32'h0, imemAddr);
      idle = 0;
      cyc = 0;
      stalled = 1'b0;
      while ((refModel.retRd.size() > 0 || refModel.stAddr.size() > 0) && !stalled) begin
         @(posedge clk);
         idle++;
         if (cyc < 2) begin
            checkValue({name, " retire after reset"}, 32'h0, 32'(retire.valid));
            checkValue({name, " data request after reset"}, 32'h0, 32'(dmemReq.valid));
         end
         if (retire.valid) begin
            idle = 0;
            if (refModel.retRd.size() == 0) begin
               $display("%s retired rd %0d with no write expected", name, retire.rd);
               errCount++;
            end else begin
               checkValue({name, " retire rd"}, 32'(refModel.retRd.pop_front()),
                          32'(retire.rd));
               checkValue({name, " retire data"}, refModel.retData.pop_front(),
                          retire.data);
            end
         end
         if (dmemReq.valid && dmemReq.we) begin
            logic [31:0] mask;
            idle = 0;
            if (refModel.stAddr.size() == 0) begin
               $display("%s issued a store that the program does not contain", name);
               errCount++;
            end else begin
               mask = {{8{refModel.stBe[0][3]}}, {8{refModel.stBe[0][2]}},
                       {8{refModel.stBe[0][1]}}, {8{refModel.stBe[0][0]}}};
               checkValue({name, " store address"}, refModel.stAddr.pop_front(),
                          dmemReq.addr);
               checkValue({name, " store byte enables"}, 32'(refModel.stBe.pop_front()),
                          32'(dmemReq.byteEn));
               checkValue({name, " store data"}, refModel.stData.pop_front() & mask,
                          dmemReq.wdata & mask);
            end
         end
         if (idle > 40) begin
            $display("%s stalled waiting for a retire or a store", name);
            errCount++;
            stalled = 1'b1;
         end
         cyc++;
      end
      // The NOP tail must stay quiet
      for (int i = 0; i < 20 && !stalled; i++) begin
         @(posedge clk);
         if (retire.valid || (dmemReq.valid && dmemReq.we)) begin
            $display("%s produced a write after the program finished", name);
            errCount++;
         end
      end
      if (errCount == startErr) begin
         $display("%s: PASS", name);
         testsPassed++;
      end else begin
         $display("%s: FAIL", name);
         testsFailed++;
      end
   endtask

   initial begin
      clk = 1'b0;
      rst = 1'b1;
      imemData = nopInstr;
      dmemRdata = '0;
      errCount = 0;
      testsPassed = 0;
      testsFailed = 0;
      void'($urandom(30));
      for (int t = 0; t < numPrograms; t++)
         runTest(t);
      $display("Tests passed %0d, failed %0d", testsPassed, testsFailed);
      if (errCount == 0 && testsFailed == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

// File: verif/rvRefModel.sv
`timescale 1ns/100ps

module rvRefModel;

   logic [31:0] prog [0:127];
   logic [7:0]  mem [0:255];
   logic [31:0] regs [0:31];

   // Expected register writes and stores, in program order
   logic [4:0]  retRd [$];
   logic [31:0] retData [$];
   logic [31:0] stAddr [$];
   logic [3:0]  stBe [$];
   logic [31:0] stData [$];

   function automatic logic [31:0] aluCalc(logic [2:0] f3, logic alt, logic [31:0] a,
                                           logic [31:0] b);
      case (f3)
         3'd0:    return alt ? a - b : a + b;
         3'd1:    return a << b[4:0];
         3'd2:    return {31'b0, $signed(a) < $signed(b)};
         3'd3:    return {31'b0, a < b};
         3'd4:    return a ^ b;
         3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
         3'd6:    return a | b;
         default: return a & b;
      endcase
   endfunction

   function automatic logic branchTaken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
      case (f3)
         3'd0:    return a == b;
         3'd1:    return a != b;
         3'd4:    return $signed(a) < $signed(b);
         3'd5:    return $signed(a) >= $signed(b);
         3'd6:    return a < b;
         3'd7:    return a >= b;
         default: return 1'b0;
      endcase
   endfunction

   task automatic runProgram();
      logic [31:0] pc;
      logic [31:0] ins;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] res;
      logic [31:0] nextPc;
      logic [31:0] addr;
      logic [31:0] word;
      logic [31:0] immI;
      logic [31:0] immS;
      logic [31:0] immB;
      logic [31:0] immJ;
      logic [3:0]  be;
      logic [2:0]  f3;
      logic [4:0]  rd;
      logic        wr;
      int          steps;
      for (int i = 0; i < 32; i++)
         regs[i] = '0;
      retRd.delete();
      retData.delete();
      stAddr.delete();
      stBe.delete();
      stData.delete();
      pc = '0;
      steps = 0;
      // Everything past the program body is NOP, so stop there
      while (pc < 32'd512 && steps < 2000) begin
         ins = prog[pc[8:2]];
         a = regs[ins[19:15]];
         b = regs[ins[24:20]];
         f3 = ins[14:12];
         rd = ins[11:7];
         immI = {{20{ins[31]}}, ins[31:20]};
         immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
         immB = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
         immJ = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
         nextPc = pc + 32'd4;
         wr = 1'b0;
         res = '0;
         case (ins[6:0])
            7'b0110111: begin
               res = {ins[31:12], 12'b0};
               wr = 1'b1;
            end
            7'b0010111: begin
               res = pc + {ins[31:12], 12'b0};
               wr = 1'b1;
            end
            7'b1101111: begin
               res = pc + 32'd4;
               wr = 1'b1;
               nextPc = pc + immJ;
            end
            7'b1100111: begin
               res = pc + 32'd4;
               wr = 1'b1;
               nextPc = (a + immI) & ~32'd1;
            end
            7'b1100011: begin
               if (branchTaken(f3, a, b))
                  nextPc = pc + immB;
            end
            7'b0000011: begin
               addr = a + immI;
               word = {mem[{addr[7:2], 2'd3}], mem[{addr[7:2], 2'd2}],
                       mem[{addr[7:2], 2'd1}], mem[{addr[7:2], 2'd0}]};
               word = word >> (8 * addr[1:0]);
               case (f3)
                  3'd0:    res = {{24{word[7]}}, word[7:0]};
                  3'd1:    res = {{16{word[15]}}, word[15:0]};
                  3'd4:    res = {24'b0, word[7:0]};
                  3'd5:    res = {16'b0, word[15:0]};
                  default: res = word;
               endcase
               wr = 1'b1;
            end
            7'b0100011: begin
               addr = a + immS;
               case (f3[1:0])
                  2'd0:    be = 4'b0001 << addr[1:0];
                  2'd1:    be = 4'b0011 << addr[1:0];
                  default: be = 4'b1111;
               endcase
               word = b << (8 * addr[1:0]);
               for (int i = 0; i < 4; i++)
                  if (be[i])
                     mem[{addr[7:2], i[1:0]}] = word[8*i +: 8];
               stAddr.push_back(addr);
               stBe.push_back(be);
               stData.push_back(word);
            end
            7'b0010011: begin
               // Only the right shift uses bit 30 as a mode bit
               res = aluCalc(f3, (f3 == 3'd5) && ins[30], a, immI);
               wr = 1'b1;
            end
            7'b0110011: begin
               res = aluCalc(f3, ins[30], a, b);
               wr = 1'b1;
            end
            default: ;
         endcase
         if (wr && rd != 5'd0) begin
            regs[rd] = res;
            retRd.push_back(rd);
            retData.push_back(res);
         end
         pc = nextPc;
         steps++;
      end
   endtask

endmodule

// File: hw/cpuCore.sv
`timescale 1ns/100ps

module cpuCore import rvPkg::*; #(
   parameter logic [31:0] resetPc = 32'h0000_0000
) (
   input  logic        clk,
   input  logic        rst,
   input  logic [31:0] imemData,
   input  logic [31:0] dmemRdata,
   output logic [31:0] imemAddr,
   output dmemReq_t    dmemReq,
   output retire_t     retire
);

   // Fetch and decode
   logic [31:0] pc;
   logic        decValid;
   logic [31:0] decInstr;
   logic [31:0] decPc;
   logic [31:0] imm;
   logic [31:0] rfData1;
   logic [31:0] rfData2;
   immType_e    immType;

   // Execute
   logic [31:0] exPc;
   logic [31:0] exRs1;
   logic [31:0] exRs2;
   logic [31:0] exImm;
   logic [4:0]  exRd;
   exCtrl_t     exCtrl;
   logic [31:0] aluResult;
   logic [31:0] storeVal;
   logic        brTaken;
   logic        kill;
   logic [31:0] lsWdata;
   logic [3:0]  lsByteEn;

   // Memory and writeback
   logic [31:0] wbAluVal;
   logic [31:0] wbLinkVal;
   logic [1:0]  wbAddrLow;
   logic [4:0]  wbRd;
   wbCtrl_t     wbCtrl;
   logic [31:0] loadVal;
   logic [31:0] wbVal;
   fwd_t        fwd;

   // Redirect goes out in the same cycle the branch resolves
   assign imemAddr = kill ? aluResult : pc;

   always_ff @(posedge clk) begin
      if (rst) begin
         pc       <= resetPc;
         decValid <= 1'b0;
      end else begin
         pc       <= imemAddr + 32'd4;
         decValid <= 1'b1;
      end
   end

   // Nothing has been fetched yet in the first cycle after reset
   assign decInstr = decValid ? imemData : nopInstr;

   pipeControl pipeControl_inst (
      .clk     (clk),
      .rst     (rst),
      .instr   (decInstr),
      .brTaken (brTaken),
      .immType (immType),
      .exCtrl  (exCtrl),
      .wbCtrl  (wbCtrl),
      .fwd     (fwd),
      .exRd    (exRd),
      .wbRd    (wbRd),
      .kill    (kill)
   );

   immGen immGen_inst (
      .instr   (decInstr),
      .immType (immType),
      .imm     (imm)
   );

   regFile regFile_inst (
      .clk     (clk),
      .rst     (rst),
      .rs1     (decInstr[19:15]),
      .rs2     (decInstr[24:20]),
      .rd      (wbRd),
      .wrEn    (wbCtrl.regWrEn),
      .wrData  (wbVal),
      .rdData1 (rfData1),
      .rdData2 (rfData2)
   );

   always_ff @(posedge clk) begin
      decPc     <= imemAddr;
      exPc      <= decPc;
      exRs1     <= fwd.decA ? wbVal : rfData1;
      exRs2     <= fwd.decB ? wbVal : rfData2;
      exImm     <= imm;
      wbAluVal  <= aluResult;
      wbLinkVal <= exPc + 32'd4;
      wbAddrLow <= aluResult[1:0];
   end

   execUnit execUnit_inst (
      .ctrl      (exCtrl),
      .pc        (exPc),
      .rs1Val    (exRs1),
      .rs2Val    (exRs2),
      .imm       (exImm),
      .wbVal     (wbVal),
      .fwdA      (fwd.exA),
      .fwdB      (fwd.exB),
      .aluResult (aluResult),
      .storeVal  (storeVal),
      .brTaken   (brTaken)
   );

   loadStoreAlign loadStoreAlign_inst (
      .storeVal   (storeVal),
      .addr       (aluResult),
      .memSize    (exCtrl.memSize),
      .loadFunct3 (wbCtrl.loadFunct3),
      .wbAddrLow  (wbAddrLow),
      .rdata      (dmemRdata),
      .wdata      (lsWdata),
      .byteEn     (lsByteEn),
      .loadVal    (loadVal)
   );

   assign dmemReq.valid  = exCtrl.memRead || exCtrl.memWrite;
   assign dmemReq.we     = exCtrl.memWrite;
   assign dmemReq.addr   = aluResult;
   assign dmemReq.wdata  = lsWdata;
   assign dmemReq.byteEn = exCtrl.memWrite ? lsByteEn : 4'b0000;

   always_comb begin
      case (wbCtrl.wbSel)
         wbMem:   wbVal = loadVal;
         wbLink:  wbVal = wbLinkVal;
         default: wbVal = wbAluVal;
      endcase
   end

   assign retire.valid = wbCtrl.regWrEn && (wbRd != 5'd0);
   assign retire.rd    = wbRd;
   assign retire.data  = wbVal;

   // A load to a live register retires exactly one cycle after its request
   assert property (@(posedge clk) disable iff (rst)
      (exCtrl.memRead && exRd != 5'd0) |=> (retire.valid && retire.rd == $past(exRd)));

endmodule

// File: hw/loadStoreAlign.sv
`timescale 1ns/100ps

module loadStoreAlign (
   input  logic [31:0] storeVal,
   input  logic [31:0] addr,
   input  logic [1:0]  memSize,
   input  logic [2:0]  loadFunct3,
   input  logic [1:0]  wbAddrLow,
   input  logic [31:0] rdata,
   output logic [31:0] wdata,
   output logic [3:0]  byteEn,
   output logic [31:0] loadVal
);

   logic [31:0] laneData;

   // Store data is replicated so the enabled lanes pick it up
   always_comb begin
      case (memSize)
         2'b00: begin
            wdata  = {4{storeVal[7:0]}};
            byteEn = 4'b0001 << addr[1:0];
         end
         2'b01: begin
            wdata  = {2{storeVal[15:0]}};
            byteEn = addr[1] ? 4'b1100 : 4'b0011;
         end
         default: begin
            wdata  = storeVal;
            byteEn = 4'b1111;
         end
      endcase
   end

   // Move the addressed lane down to bit 0
   assign laneData = rdata >> {wbAddrLow, 3'b000};

   always_comb begin
      case (loadFunct3)
         3'b000:  loadVal = {{24{laneData[7]}}, laneData[7:0]};
         3'b001:  loadVal = {{16{laneData[15]}}, laneData[15:0]};
         3'b100:  loadVal = {24'b0, laneData[7:0]};
         3'b101:  loadVal = {16'b0, laneData[15:0]};
         default: loadVal = laneData;
      endcase
   end

endmodule

// File: hw/execUnit.sv
`timescale 1ns/100ps

module execUnit import rvPkg::*; (
   input  exCtrl_t     ctrl,
   input  logic [31:0] pc,
   input  logic [31:0] rs1Val,
   input  logic [31:0] rs2Val,
   input  logic [31:0] imm,
   input  logic [31:0] wbVal,
   input  logic        fwdA,
   input  logic        fwdB,
   output logic [31:0] aluResult,
   output logic [31:0] storeVal,
   output logic        brTaken
);

   logic [31:0] opA;
   logic [31:0] opB;
   logic [31:0] aluA;
   logic [31:0] aluB;
   logic [31:0] aluOut;
   logic        isEq;
   logic        isLt;
   logic        cond;

   // Writeback result overrides the operand read one cycle ago
   assign opA = fwdA ? wbVal : rs1Val;
   assign opB = fwdB ? wbVal : rs2Val;

   assign aluA = ctrl.aSel ? pc : opA;
   assign aluB = ctrl.bSel ? imm : opB;

   always_comb begin
      case (ctrl.aluOp)
         aluSub:   aluOut = aluA - aluB;
         aluSll:   aluOut = aluA << aluB[4:0];
         aluSlt:   aluOut = {31'b0, $signed(aluA) < $signed(aluB)};
         aluSltu:  aluOut = {31'b0, aluA < aluB};
         aluXor:   aluOut = aluA ^ aluB;
         aluSrl:   aluOut = aluA >> aluB[4:0];
         aluSra:   aluOut = $signed(aluA) >>> aluB[4:0];
         aluOr:    aluOut = aluA | aluB;
         aluAnd:   aluOut = aluA & aluB;
         aluPassB: aluOut = aluB;
         default:  aluOut = aluA + aluB;
      endcase
   end

   // JALR target drops bit 0, JAL targets are even already
   assign aluResult = ctrl.isJump ? {aluOut[31:1], 1'b0} : aluOut;
   assign storeVal  = opB;

   assign isEq = (opA == opB);
   assign isLt = ctrl.brUn ? (opA < opB) : ($signed(opA) < $signed(opB));

   always_comb begin
      case (ctrl.brFunct3)
         3'b000:        cond = isEq;
         3'b001:        cond = !isEq;
         3'b100, 3'b110: cond = isLt;
         3'b101, 3'b111: cond = !isLt;
         default:       cond = 1'b0;
      endcase
   end

   assign brTaken = ctrl.isBranch && cond;

endmodule

// File: hw/regFile.sv
`timescale 1ns/100ps

module regFile (
   input  logic        clk,
   input  logic        rst,
   input  logic [4:0]  rs1,
   input  logic [4:0]  rs2,
   input  logic [4:0]  rd,
   input  logic        wrEn,
   input  logic [31:0] wrData,
   output logic [31:0] rdData1,
   output logic [31:0] rdData2
);

   // x0 has no storage
   logic [31:0] regs [1:31];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 1; i < 32; i++)
            regs[i] <= '0;
      end else if (wrEn && (rd != 5'd0)) begin
         regs[rd] <= wrData;
      end
   end

   assign rdData1 = (rs1 == 5'd0) ? '0 : regs[rs1];
   assign rdData2 = (rs2 == 5'd0) ? '0 : regs[rs2];

   // A write shows up on the first read of that register after the edge
   assert property (@(posedge clk) disable iff (rst)
      (wrEn && rd != 5'd0) ##1 (rs1 == $past(rd)) |-> (rdData1 == $past(wrData)));

endmodule

// File: hw/immGen.sv
`timescale 1ns/100ps

module immGen import rvPkg::*; (
   input  logic [31:0] instr,
   input  immType_e    immType,
   output logic [31:0] imm
);

   always_comb begin
      case (immType)
         immI: imm = {{20{instr[31]}}, instr[31:20]};
         immS: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
         // Branch offsets are in units of two bytes
         immB: begin
            imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                   instr[11:8], 1'b0};
         end
         immU: imm = {instr[31:12], 12'b0};
         immJ: begin
            imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                   instr[30:21], 1'b0};
         end
         default: imm = '0;
      endcase
   end

endmodule

// File: hw/pipeControl.sv
`timescale 1ns/100ps

module pipeControl import rvPkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  logic [31:0] instr,
   input  logic        brTaken,
   output immType_e    immType,
   output exCtrl_t     exCtrl,
   output wbCtrl_t     wbCtrl,
   output fwd_t        fwd,
   output logic [4:0]  exRd,
   output logic [4:0]  wbRd,
   output logic        kill
);

   logic [31:0] exInstr;
   logic [31:0] wbInstr;
   opcode_e     decOp;
   opcode_e     exOp;
   opcode_e     wbOp;
   logic        wbWrites;

   function automatic logic usesRs1(opcode_e op);
      return op inside {LOAD, STORE, BRANCH, JALR, OP, OPIMM};
   endfunction

   function automatic logic usesRs2(opcode_e op);
      return op inside {STORE, BRANCH, OP};
   endfunction

   assign decOp = opcode_e'(instr[6:2]);
   assign exOp  = opcode_e'(exInstr[6:2]);
   assign wbOp  = opcode_e'(wbInstr[6:2]);
   assign exRd  = exInstr[11:7];
   assign wbRd  = wbInstr[11:7];

   // Wrong-path instruction in decode is dropped on a redirect
   always_ff @(posedge clk) begin
      if (rst) begin
         exInstr <= nopInstr;
         wbInstr <= nopInstr;
      end else begin
         exInstr <= kill ? nopInstr : instr;
         wbInstr <= exInstr;
      end
   end

   always_comb begin
      case (decOp)
         LOAD, JALR, OPIMM: immType = immI;
         STORE:             immType = immS;
         BRANCH:            immType = immB;
         JAL:               immType = immJ;
         AUIPC, LUI:        immType = immU;
         default:           immType = immNone;
      endcase
   end

   // Execute stage controls
   always_comb begin
      exCtrl       = '0;
      exCtrl.aluOp = aluAdd;
      case (exOp)
         LOAD: begin
            exCtrl.bSel    = 1'b1;
            exCtrl.memRead = 1'b1;
            exCtrl.memSize = exInstr[13:12];
         end
         STORE: begin
            exCtrl.bSel     = 1'b1;
            exCtrl.memWrite = 1'b1;
            exCtrl.memSize  = exInstr[13:12];
         end
         BRANCH: begin
            // ALU computes the target, the comparator decides
            exCtrl.aSel     = 1'b1;
            exCtrl.bSel     = 1'b1;
            exCtrl.isBranch = 1'b1;
            exCtrl.brFunct3 = exInstr[14:12];
            exCtrl.brUn     = exInstr[13];
         end
         JALR: begin
            exCtrl.bSel   = 1'b1;
            exCtrl.isJump = 1'b1;
         end
         JAL: begin
            exCtrl.aSel   = 1'b1;
            exCtrl.bSel   = 1'b1;
            exCtrl.isJump = 1'b1;
         end
         OP: begin
            exCtrl.aluOp = aluOp_e'({exInstr[30], exInstr[14:12]});
         end
         OPIMM: begin
            exCtrl.bSel = 1'b1;
            // Bit 30 is part of the immediate except on shifts
            if (exInstr[13:12] == 2'b01)
               exCtrl.aluOp = aluOp_e'({exInstr[30], exInstr[14:12]});
            else
               exCtrl.aluOp = aluOp_e'({1'b0, exInstr[14:12]});
         end
         AUIPC: begin
            exCtrl.aSel = 1'b1;
            exCtrl.bSel = 1'b1;
         end
         LUI: begin
            exCtrl.bSel  = 1'b1;
            exCtrl.aluOp = aluPassB;
         end
         default: ;
      endcase
   end

   assign kill = brTaken || exCtrl.isJump;

   // Writeback stage controls
   always_comb begin
      wbCtrl.regWrEn    = 1'b0;
      wbCtrl.wbSel      = wbAlu;
      wbCtrl.loadFunct3 = 3'b010;
      case (wbOp)
         LOAD: begin
            wbCtrl.regWrEn    = 1'b1;
            wbCtrl.wbSel      = wbMem;
            wbCtrl.loadFunct3 = wbInstr[14:12];
         end
         JAL, JALR: begin
            wbCtrl.regWrEn = 1'b1;
            wbCtrl.wbSel   = wbLink;
         end
         OP, OPIMM, AUIPC, LUI: wbCtrl.regWrEn = 1'b1;
         default: ;
      endcase
   end

   assign wbWrites = wbCtrl.regWrEn && (wbRd != 5'd0);

   assign fwd.decA = wbWrites && (wbRd == instr[19:15]) && usesRs1(decOp);
   assign fwd.decB = wbWrites && (wbRd == instr[24:20]) && usesRs2(decOp);
   assign fwd.exA  = wbWrites && (wbRd == exInstr[19:15]) && usesRs1(exOp);
   assign fwd.exB  = wbWrites && (wbRd == exInstr[24:20]) && usesRs2(exOp);

   // The slot behind a redirect is a bubble
   assert property (@(posedge clk) disable iff (rst)
      kill |=> !(kill || exCtrl.memRead || exCtrl.memWrite));

endmodule

// File: hw/rvPkg.sv
package rvPkg;

   // Major opcode, instruction bits 6 to 2
   typedef enum logic [4:0] {
      LOAD   = 5'b00000,
      OPIMM  = 5'b00100,
      AUIPC  = 5'b00101,
      STORE  = 5'b01000,
      OP     = 5'b01100,
      LUI    = 5'b01101,
      BRANCH = 5'b11000,
      JALR   = 5'b11001,
      JAL    = 5'b11011
   } opcode_e;

   // Encoded as {instr[30], funct3}; passB takes a free code for LUI
   typedef enum logic [3:0] {
      aluAdd   = 4'b0000,
      aluSll   = 4'b0001,
      aluSlt   = 4'b0010,
      aluSltu  = 4'b0011,
      aluXor   = 4'b0100,
      aluSrl   = 4'b0101,
      aluOr    = 4'b0110,
      aluAnd   = 4'b0111,
      aluSub   = 4'b1000,
      aluPassB = 4'b1001,
      aluSra   = 4'b1101
   } aluOp_e;

   typedef enum logic [2:0] {
      immI,
      immS,
      immB,
      immU,
      immJ,
      immNone
   } immType_e;

   typedef enum logic [1:0] {
      wbMem  = 2'd0,
      wbAlu  = 2'd1,
      wbLink = 2'd2
   } wbSel_e;

   typedef struct packed {
      logic       aSel;
      logic       bSel;
      logic       brUn;
      aluOp_e     aluOp;
      logic       isBranch;
      logic       isJump;
      logic [2:0] brFunct3;
      logic       memRead;
      logic       memWrite;
      logic [1:0] memSize;
   } exCtrl_t;

   typedef struct packed {
      logic       regWrEn;
      wbSel_e     wbSel;
      logic [2:0] loadFunct3;
   } wbCtrl_t;

   typedef struct packed {
      logic decA;
      logic decB;
      logic exA;
      logic exB;
   } fwd_t;

   typedef struct packed {
      logic        valid;
      logic        we;
      logic [31:0] addr;
      logic [31:0] wdata;
      logic [3:0]  byteEn;
   } dmemReq_t;

   typedef struct packed {
      logic        valid;
      logic [4:0]  rd;
      logic [31:0] data;
   } retire_t;

   // addi x0, x0, 0
   localparam logic [31:0] nopInstr = 32'h0000_0013;

endpackage
